/* rtl/ntm_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Vector modulo unit shared sizes
////////////////////////////////////////////////////////////////////////////

package ntm_pkg;

  // Operand, modulus and residue width
  localparam int DATA_SIZE = 16;

  // Scalar modulo lanes working in parallel
  localparam int LANES = 4;

  // Operand and result buffer depth
  localparam int MAX_LENGTH = 16;

  // Buffer index and lane tag width
  localparam int INDEX_SIZE = 4;

  // Job length runs from 1 to MAX_LENGTH, so one bit wider than an index
  localparam int LENGTH_SIZE = 5;

  // Lane number width
  localparam int LANE_SIZE = 2;

endpackage

/* rtl/ntm_scalar_mod.sv */
`timescale 1ns/1ps

module ntm_scalar_mod (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          lane_start,
  input  logic [ntm_pkg::DATA_SIZE-1:0] modulus,
  input  logic [ntm_pkg::DATA_SIZE-1:0] operand,
  output logic                          lane_done,
  output logic [ntm_pkg::DATA_SIZE-1:0] lane_residue
);

  ////////////////////////////////////////////////////////////////////////////
  // State and remainder
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    IDLE_STATE,
    REDUCE_STATE
  } mod_state_t;

  mod_state_t state;

  // Running remainder, one subtraction per cycle
  logic [ntm_pkg::DATA_SIZE-1:0] remainder;

  // Reduction finished this cycle
  logic finish;

  // Zero modulus passes the operand through
  // Otherwise stop once the remainder drops to the modulus or below
  assign finish = (modulus == '0) || (remainder <= modulus);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE_STATE;
      lane_done <= 1'b0;
    end else begin
      // Done is a single-cycle pulse
      lane_done <= 1'b0;
      case (state)
        IDLE_STATE: begin
          if (lane_start) begin
            state <= REDUCE_STATE;
          end
        end
        REDUCE_STATE: begin
          if (finish) begin
            lane_done <= 1'b1;
            state     <= IDLE_STATE;
          end
        end
        default: begin
          state <= IDLE_STATE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == IDLE_STATE) begin
      // Capture operand on issue
      if (lane_start) begin
        remainder <= operand;
      end
    end else if (finish) begin
      if (modulus == '0) begin
        lane_residue <= remainder;
      end else if (remainder == modulus) begin
        // Exact multiple
        lane_residue <= '0;
      end else begin
        // Below modulus, zero included
        lane_residue <= remainder;
      end
    end else begin
      remainder <= remainder - modulus;
    end
  end

  // Dispatcher only issues to an idle lane
  assert property (@(posedge CLK) disable iff (RST)
    lane_start |-> state == IDLE_STATE);

  // Modulus held steady by the dispatcher while a reduction runs
  assert property (@(posedge CLK) disable iff (RST)
    state == REDUCE_STATE |-> $stable(modulus));

endmodule

/* rtl/ntm_mod_dispatch.sv */
`timescale 1ns/1ps

module ntm_mod_dispatch (
  input  logic                                                CLK,
  input  logic                                                RST,
  input  logic                                                operand_write,
  input  logic [ntm_pkg::INDEX_SIZE-1:0]                      operand_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]                       operand,
  input  logic                                                start,
  input  logic [ntm_pkg::LENGTH_SIZE-1:0]                     length,
  input  logic [ntm_pkg::DATA_SIZE-1:0]                       modulus,
  input  logic                                                job_end,
  input  logic [ntm_pkg::LANES-1:0]                           lane_done,
  output logic                                                busy,
  output logic                                                job_start,
  output logic [ntm_pkg::LENGTH_SIZE-1:0]                     job_length,
  output logic [ntm_pkg::DATA_SIZE-1:0]                       modulus_hold,
  output logic [ntm_pkg::LANES-1:0]                           lane_start,
  output logic [ntm_pkg::DATA_SIZE-1:0]                       lane_operand,
  output logic [ntm_pkg::LANES-1:0][ntm_pkg::INDEX_SIZE-1:0]  lane_tag
);

  ////////////////////////////////////////////////////////////////////////////
  // Operand buffer
  ////////////////////////////////////////////////////////////////////////////

  logic [ntm_pkg::DATA_SIZE-1:0] operand_buffer [ntm_pkg::MAX_LENGTH];

  // Loading only between jobs
  always_ff @(posedge CLK) begin
    if (operand_write && !busy) begin
      operand_buffer[operand_index] <= operand;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue selection
  ////////////////////////////////////////////////////////////////////////////

  // Next operand to send, counts up to job_length
  logic [ntm_pkg::LENGTH_SIZE-1:0] issue_pointer;
  logic [ntm_pkg::LANES-1:0]       lane_idle;
  logic [ntm_pkg::LANE_SIZE-1:0]   lane_select;
  logic                            lane_found;
  logic                            issue_valid;

  // Lowest-numbered idle lane wins, so scan from the top down
  always_comb begin
    lane_select = '0;
    lane_found  = 1'b0;
    for (int i = ntm_pkg::LANES - 1; i >= 0; i--) begin
      if (lane_idle[i]) begin
        lane_select = i[ntm_pkg::LANE_SIZE-1:0];
        lane_found  = 1'b1;
      end
    end
  end

  assign issue_valid = busy && lane_found && (issue_pointer < job_length);

  // One-hot start to the chosen lane
  always_comb begin
    for (int i = 0; i < ntm_pkg::LANES; i++) begin
      lane_start[i] = issue_valid && (lane_select == i[ntm_pkg::LANE_SIZE-1:0]);
    end
  end

  // Shared operand bus, sampled by the started lane only
  assign lane_operand = operand_buffer[issue_pointer[ntm_pkg::INDEX_SIZE-1:0]];

  ////////////////////////////////////////////////////////////////////////////
  // Job control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy          <= 1'b0;
      job_start     <= 1'b0;
      issue_pointer <= '0;
      lane_idle     <= '1;
    end else begin
      job_start <= 1'b0;
      if (start && !busy) begin
        busy          <= 1'b1;
        job_start     <= 1'b1;
        issue_pointer <= '0;
      end else if (job_end) begin
        busy <= 1'b0;
      end else if (issue_valid) begin
        issue_pointer <= issue_pointer + 1;
      end
      // Lane busy from issue until its done pulse
      for (int i = 0; i < ntm_pkg::LANES; i++) begin
        if (lane_done[i]) begin
          lane_idle[i] <= 1'b1;
        end
        if (lane_start[i]) begin
          lane_idle[i] <= 1'b0;
        end
      end
    end
  end

  // Job parameters and per-lane tags
  always_ff @(posedge CLK) begin
    if (start && !busy) begin
      job_length   <= length;
      modulus_hold <= modulus;
    end
    for (int i = 0; i < ntm_pkg::LANES; i++) begin
      if (lane_start[i]) begin
        lane_tag[i] <= issue_pointer[ntm_pkg::INDEX_SIZE-1:0];
      end
    end
  end

  // Done only from a lane holding an issued operand
  assert property (@(posedge CLK) disable iff (RST)
    (lane_done & lane_idle) == '0);

endmodule

/* rtl/ntm_mod_collect.sv */
`timescale 1ns/1ps

module ntm_mod_collect (
  input  logic                                                CLK,
  input  logic                                                RST,
  input  logic                                                job_start,
  input  logic [ntm_pkg::LENGTH_SIZE-1:0]                     job_length,
  input  logic [ntm_pkg::LANES-1:0]                           lane_done,
  input  logic [ntm_pkg::LANES-1:0][ntm_pkg::DATA_SIZE-1:0]   lane_residue,
  input  logic [ntm_pkg::LANES-1:0][ntm_pkg::INDEX_SIZE-1:0]  lane_tag,
  output logic                                                result_enable,
  output logic [ntm_pkg::INDEX_SIZE-1:0]                      result_index,
  output logic [ntm_pkg::DATA_SIZE-1:0]                       result,
  output logic                                                ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Result buffer
  ////////////////////////////////////////////////////////////////////////////

  logic [ntm_pkg::DATA_SIZE-1:0] result_buffer [ntm_pkg::MAX_LENGTH];

  // Tags are distinct within a job, so parallel writes never collide
  always_ff @(posedge CLK) begin
    for (int i = 0; i < ntm_pkg::LANES; i++) begin
      if (lane_done[i]) begin
        result_buffer[lane_tag[i]] <= lane_residue[i];
      end
    end
  end

  // Streamed element
  assign result = result_buffer[result_index];

  ////////////////////////////////////////////////////////////////////////////
  // Completion count
  ////////////////////////////////////////////////////////////////////////////

  logic [ntm_pkg::LENGTH_SIZE-1:0] completions;
  logic [ntm_pkg::LENGTH_SIZE-1:0] done_count;
  logic [ntm_pkg::LENGTH_SIZE-1:0] last_index;
  logic                            collecting;

  // Several lanes may finish together
  always_comb begin
    completions = '0;
    for (int i = 0; i < ntm_pkg::LANES; i++) begin
      completions = completions + {{(ntm_pkg::LENGTH_SIZE - 1){1'b0}}, lane_done[i]};
    end
  end

  assign last_index = job_length - 1;

  ////////////////////////////////////////////////////////////////////////////
  // Output stream
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      collecting    <= 1'b0;
      done_count    <= '0;
      result_enable <= 1'b0;
      result_index  <= '0;
      ready         <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (job_start) begin
        collecting <= 1'b1;
        done_count <= '0;
      end else begin
        done_count <= done_count + completions;
      end
      // All residues in, start reading out from index 0
      if (collecting && !job_start && done_count == job_length) begin
        collecting    <= 1'b0;
        result_enable <= 1'b1;
        result_index  <= '0;
      end
      if (result_enable) begin
        if ({1'b0, result_index} == last_index) begin
          // Last element out, ready follows
          result_enable <= 1'b0;
          ready         <= 1'b1;
        end else begin
          result_index <= result_index + 1;
        end
      end
    end
  end

  // Dispatcher never issues past job_length
  assert property (@(posedge CLK) disable iff (RST)
    collecting |-> done_count <= job_length);

endmodule

/* rtl/ntm_vector_mod.sv */
`timescale 1ns/1ps

module ntm_vector_mod (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            operand_write,
  input  logic [ntm_pkg::INDEX_SIZE-1:0]  operand_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]   operand,
  input  logic                            start,
  input  logic [ntm_pkg::LENGTH_SIZE-1:0] length,
  input  logic [ntm_pkg::DATA_SIZE-1:0]   modulus,
  output logic                            busy,
  output logic                            result_enable,
  output logic [ntm_pkg::INDEX_SIZE-1:0]  result_index,
  output logic [ntm_pkg::DATA_SIZE-1:0]   result,
  output logic                            ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  logic                                               job_start;
  logic [ntm_pkg::LENGTH_SIZE-1:0]                    job_length;
  logic [ntm_pkg::DATA_SIZE-1:0]                      modulus_hold;
  logic [ntm_pkg::LANES-1:0]                          lane_start;
  logic [ntm_pkg::DATA_SIZE-1:0]                      lane_operand;
  logic [ntm_pkg::LANES-1:0][ntm_pkg::INDEX_SIZE-1:0] lane_tag;
  logic [ntm_pkg::LANES-1:0]                          lane_done;
  logic [ntm_pkg::LANES-1:0][ntm_pkg::DATA_SIZE-1:0]  lane_residue;

  // Operand buffer and in-order issue
  ntm_mod_dispatch i_ntm_mod_dispatch (
    .CLK          (CLK),
    .RST          (RST),
    .operand_write(operand_write),
    .operand_index(operand_index),
    .operand      (operand),
    .start        (start),
    .length       (length),
    .modulus      (modulus),
    .job_end      (ready),
    .lane_done    (lane_done),
    .busy         (busy),
    .job_start    (job_start),
    .job_length   (job_length),
    .modulus_hold (modulus_hold),
    .lane_start   (lane_start),
    .lane_operand (lane_operand),
    .lane_tag     (lane_tag)
  );

  // Scalar lanes, finish out of order
  for (genvar g = 0; g < ntm_pkg::LANES; g++) begin : g_lane
    ntm_scalar_mod i_ntm_scalar_mod (
      .CLK         (CLK),
      .RST         (RST),
      .lane_start  (lane_start[g]),
      .modulus     (modulus_hold),
      .operand     (lane_operand),
      .lane_done   (lane_done[g]),
      .lane_residue(lane_residue[g])
    );
  end

  // Reordering by tag and result stream
  ntm_mod_collect i_ntm_mod_collect (
    .CLK          (CLK),
    .RST          (RST),
    .job_start    (job_start),
    .job_length   (job_length),
    .lane_done    (lane_done),
    .lane_residue (lane_residue),
    .lane_tag     (lane_tag),
    .result_enable(result_enable),
    .result_index (result_index),
    .result       (result),
    .ready        (ready)
  );

endmodule

/* test/ntm_vector_mod_check.sv */
`timescale 1ns/1ps

module ntm_vector_mod_check (
  input  logic                                                 CLK,
  input  logic                                                 RST,
  input  logic                                                 start,
  input  logic                                                 busy,
  input  logic                                                 result_enable,
  input  logic [ntm_pkg::INDEX_SIZE-1:0]                       result_index,
  input  logic [ntm_pkg::DATA_SIZE-1:0]                        result,
  input  logic                                                 ready,
  input  logic [ntm_pkg::DATA_SIZE-1:0]                        expect_modulus,
  input  logic [ntm_pkg::LENGTH_SIZE-1:0]                      expect_length,
  input  logic [ntm_pkg::MAX_LENGTH-1:0][ntm_pkg::DATA_SIZE-1:0] expect_operands,
  output int                                                   check_count,
  output int                                                   error_count
);

  // Per-job tracking
  int element_count;
  bit ready_seen;
  bit ready_last;
  bit started;

  // Residue rule: zero modulus passes the operand through
  function automatic logic [ntm_pkg::DATA_SIZE-1:0] expected_residue(
    input logic [ntm_pkg::DATA_SIZE-1:0] value,
    input logic [ntm_pkg::DATA_SIZE-1:0] divisor
  );
    if (divisor == '0) begin
      return value;
    end
    return value % divisor;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Sampling at the rising edge, values of the cycle just ended
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    int errs;
    int checks;
    logic [ntm_pkg::DATA_SIZE-1:0] want;
    errs = 0;
    checks = 0;
    if (RST) begin
      started       = 1'b0;
      element_count = 0;
      ready_seen    = 1'b0;
      ready_last    = 1'b0;
      check_count   <= 0;
      error_count   <= 0;
    end else begin
      // Nothing may move before the first accepted start
      if (!started && (busy || result_enable || ready)) begin
        $display("%0t: outputs active before the first start", $time);
        errs++;
      end
      // Accepted start opens a new job, a start while busy does not
      if (start && !busy) begin
        started       = 1'b1;
        element_count = 0;
        ready_seen    = 1'b0;
      end
      if (result_enable) begin
        if (!busy) begin
          $display("%0t: result_enable high while not busy", $time);
          errs++;
        end
        if (element_count >= int'(expect_length)) begin
          $display("%0t: extra result element beyond length %0d", $time, expect_length);
          errs++;
        end else begin
          // Stream must run in index order, each index once
          checks++;
          if (int'(result_index) != element_count) begin
            $display("[FAIL] %0t result_index: expected %0d, got %0d",
                     $time, element_count, result_index);
            errs++;
          end
          want = expected_residue(expect_operands[element_count], expect_modulus);
          if (result !== want) begin
            $display("[FAIL] %0t result: expected %h, got %h", $time, want, result);
            errs++;
          end
          element_count++;
        end
      end
      if (ready) begin
        if (ready_seen) begin
          $display("%0t: second ready pulse in one job", $time);
          errs++;
        end
        if (element_count != int'(expect_length)) begin
          $display("%0t: ready after %0d of %0d elements",
                   $time, element_count, expect_length);
          errs++;
        end
        ready_seen = 1'b1;
      end
      // Busy drops the cycle after ready
      if (ready_last && busy) begin
        $display("%0t: busy still high one cycle after ready", $time);
        errs++;
      end
      ready_last  = ready;
      check_count <= check_count + checks;
      error_count <= error_count + errs;
    end
  end

endmodule

/* test/ntm_vector_mod_tb.sv */
`timescale 1ns/1ps

module ntm_vector_mod_tb;

  localparam int NUM_TESTS      = 7;
  localparam int TIMEOUT_CYCLES = 5000;

  logic                            CLK;
  logic                            RST;
  logic                            operand_write;
  logic [ntm_pkg::INDEX_SIZE-1:0]  operand_index;
  logic [ntm_pkg::DATA_SIZE-1:0]   operand;
  logic                            start;
  logic [ntm_pkg::LENGTH_SIZE-1:0] length;
  logic [ntm_pkg::DATA_SIZE-1:0]   modulus;
  logic                            busy;
  logic                            result_enable;
  logic [ntm_pkg::INDEX_SIZE-1:0]  result_index;
  logic [ntm_pkg::DATA_SIZE-1:0]   result;
  logic                            ready;

  // Job currently expected by the checker
  logic [ntm_pkg::DATA_SIZE-1:0]                         expect_modulus;
  logic [ntm_pkg::LENGTH_SIZE-1:0]                       expect_length;
  logic [ntm_pkg::MAX_LENGTH-1:0][ntm_pkg::DATA_SIZE-1:0] expect_operands;
  int check_count;
  int error_count;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table, one row per job
  ////////////////////////////////////////////////////////////////////////////

  logic [ntm_pkg::DATA_SIZE-1:0]                         tbl_modulus    [NUM_TESTS];
  logic [ntm_pkg::LENGTH_SIZE-1:0]                       tbl_length     [NUM_TESTS];
  bit                                                    tbl_random     [NUM_TESTS];
  bit                                                    tbl_busy_start [NUM_TESTS];
  logic [ntm_pkg::MAX_LENGTH-1:0][ntm_pkg::DATA_SIZE-1:0] tbl_operands   [NUM_TESTS];

  integer seed     = 32'h562f;
  int     timeouts = 0;
  int     tests    = 0;

  ntm_vector_mod i_ntm_vector_mod (
    .CLK          (CLK),
    .RST          (RST),
    .operand_write(operand_write),
    .operand_index(operand_index),
    .operand      (operand),
    .start        (start),
    .length       (length),
    .modulus      (modulus),
    .busy         (busy),
    .result_enable(result_enable),
    .result_index (result_index),
    .result       (result),
    .ready        (ready)
  );

  ntm_vector_mod_check i_ntm_vector_mod_check (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .busy           (busy),
    .result_enable  (result_enable),
    .result_index   (result_index),
    .result         (result),
    .ready          (ready),
    .expect_modulus (expect_modulus),
    .expect_length  (expect_length),
    .expect_operands(expect_operands),
    .check_count    (check_count),
    .error_count    (error_count)
  );

  // 20 ns clock
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic set_row(input int t, input logic [ntm_pkg::DATA_SIZE-1:0] mod,
                         input logic [ntm_pkg::LENGTH_SIZE-1:0] len,
                         input bit rnd, input bit busy_start);
    tbl_modulus[t]    = mod;
    tbl_length[t]     = len;
    tbl_random[t]     = rnd;
    tbl_busy_start[t] = busy_start;
    tbl_operands[t]   = '0;
  endtask

  // First six operands of a fixed row
  task automatic set_operands(input int t, input logic [15:0] a, input logic [15:0] b,
                              input logic [15:0] c, input logic [15:0] d,
                              input logic [15:0] e, input logic [15:0] f);
    tbl_operands[t][0] = a;
    tbl_operands[t][1] = b;
    tbl_operands[t][2] = c;
    tbl_operands[t][3] = d;
    tbl_operands[t][4] = e;
    tbl_operands[t][5] = f;
  endtask

  // Wait for a ready pulse, then for busy low; zero on timeout
  task automatic wait_job_end(output bit ok);
    ok = 1'b0;
    for (int c = 0; c < TIMEOUT_CYCLES && !ok; c++) begin
      @(posedge CLK);
      ok = ready;
    end
    if (!ok) begin
      $display("%0t: no ready pulse within %0d cycles", $time, TIMEOUT_CYCLES);
    end else begin
      ok = 1'b0;
      for (int c = 0; c < TIMEOUT_CYCLES && !ok; c++) begin
        @(posedge CLK);
        ok = !busy;
      end
      if (!ok) begin
        $display("%0t: busy did not drop after ready", $time);
      end
    end
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One table row: load, start, optional ignored start, wait
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_row(input int t);
    int          errors_before;
    bit          ok;
    logic [31:0] rand_word;
    errors_before = error_count;
    // Random operands kept to 10 bits so lane latency stays bounded
    for (int i = 0; i < ntm_pkg::MAX_LENGTH; i++) begin
      rand_word = $random(seed);
      if (tbl_random[t]) begin
        expect_operands[i] = rand_word[ntm_pkg::DATA_SIZE-1:0] & 16'h03ff;
      end else begin
        expect_operands[i] = tbl_operands[t][i];
      end
    end
    for (int i = 0; i < int'(tbl_length[t]); i++) begin
      operand_write = 1'b1;
      operand_index = i[ntm_pkg::INDEX_SIZE-1:0];
      operand       = expect_operands[i];
      @(posedge CLK);
      #1;
    end
    operand_write  = 1'b0;
    expect_modulus = tbl_modulus[t];
    expect_length  = tbl_length[t];
    start          = 1'b1;
    length         = tbl_length[t];
    modulus        = tbl_modulus[t];
    @(posedge CLK);
    #1;
    start = 1'b0;
    if (tbl_busy_start[t]) begin
      // Start mid-job with other parameters, must be dropped
      repeat (3) @(posedge CLK);
      #1;
      start   = 1'b1;
      length  = 5'd3;
      modulus = 16'd2;
      @(posedge CLK);
      #1;
      start = 1'b0;
    end
    wait_job_end(ok);
    tests++;
    if (!ok) begin
      timeouts++;
      $display("test %0d: timed out waiting for the job to finish", t);
    end else begin
      $display("test %0d: modulus %0d, length %0d, %0d errors",
               t, tbl_modulus[t], tbl_length[t], error_count - errors_before);
    end
  endtask

  initial begin
    RST            = 1'b1;
    operand_write  = 1'b0;
    operand_index  = '0;
    operand        = '0;
    start          = 1'b0;
    length         = '0;
    modulus        = '0;
    expect_modulus = '0;
    expect_length  = '0;
    expect_operands = '0;

    // Random 16, edges, zero modulus, length 1, length 5, back-to-back
    set_row(0, 16'd7, 5'd16, 1'b1, 1'b0);
    set_row(1, 16'd100, 5'd5, 1'b0, 1'b0);
    set_operands(1, 16'd0, 16'd100, 16'd99, 16'd1000, 16'd250, 16'd0);
    set_row(2, 16'd0, 5'd6, 1'b0, 1'b0);
    set_operands(2, 16'd0, 16'd1, 16'hffff, 16'h1234, 16'h8000, 16'd42);
    set_row(3, 16'd13, 5'd1, 1'b0, 1'b0);
    set_operands(3, 16'd500, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0);
    set_row(4, 16'd3, 5'd5, 1'b1, 1'b0);
    set_row(5, 16'd11, 5'd16, 1'b1, 1'b1);
    set_row(6, 16'd5, 5'd8, 1'b1, 1'b1);

    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Idle stretch, checker flags any output activity
    repeat (10) @(posedge CLK);
    #1;
    tests++;
    $display("test idle: %0d errors after reset", error_count);

    for (int t = 0; t < NUM_TESTS; t++) begin
      if (timeouts != 0) begin
        break;
      end
      apply_row(t);
    end

    repeat (5) @(posedge CLK);
    #1;
    $display("tests %0d, checks %0d, errors %0d, timeouts %0d",
             tests, check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0 && check_count > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/ntm_pkg.sv
rtl/ntm_scalar_mod.sv
rtl/ntm_mod_dispatch.sv
rtl/ntm_mod_collect.sv
rtl/ntm_vector_mod.sv
test/ntm_vector_mod_check.sv
test/ntm_vector_mod_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build the vector modulo testbench with Verilator and run it

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_vector_mod_tb -f sim.f \
  && ./obj_dir/Vntm_vector_mod_tb > sim.log 2>&1 \
  || echo "Build or simulation run did not complete"

cat sim.log 2>/dev/null

grep -q "Simulation passed" sim.log && exit 0 || exit 1
